//--- common/execute_settings.svh
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// Datapath and address width
`define XLEN 32

// Register index width, x0..x31
`define REG_ADDR_W 5

`endif

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV32I major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // Shared by OP and OP_IMM, funct7 bit 5 picks SUB / SRA
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

//--- common/exe_ctrl_pkg.sv
package exe_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // Operand B straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_e;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } op_b_sel_e;

    // Write-back source, carried down to the later stages
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_sel_e;

    // Bit 1 = MEM, bit 0 = WB; MEM wins when both are set
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

endpackage

//--- execute/alu_control.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module alu_control (
    input  logic [`XLEN-1:0]          instr,
    output exe_ctrl_pkg::alu_op_e     alu_op,
    output exe_ctrl_pkg::op_a_sel_e   op_a_sel,
    output exe_ctrl_pkg::op_b_sel_e   op_b_sel,
    output rv_isa_pkg::imm_fmt_e      imm_fmt,
    output exe_ctrl_pkg::result_sel_e result_sel,
    output logic                      reg_write,
    output logic                      mem_write,
    output logic                      is_branch,
    output logic                      is_jump
);
    import rv_isa_pkg::*;
    import exe_ctrl_pkg::*;

    opcode_e  opcode;
    alu_f3_e  funct3;
    logic     funct7_b5;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = alu_f3_e'(instr[14:12]);
    assign funct7_b5 = instr[30];

    // alt_sub only honoured for register ops, ADDI has no SUB form
    function automatic alu_op_e f3_to_op(input alu_f3_e f3, input logic alt,
                                         input logic alt_sub);
        case (f3)
            F3_ADD_SUB: f3_to_op = (alt && alt_sub) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_to_op = ALU_SLL;
            F3_SLT:     f3_to_op = ALU_SLT;
            F3_SLTU:    f3_to_op = ALU_SLTU;
            F3_XOR:     f3_to_op = ALU_XOR;
            F3_SRL_SRA: f3_to_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_to_op = ALU_OR;
            default:    f3_to_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        // NOP unless the opcode says otherwise
        alu_op     = ALU_ADD;
        op_a_sel   = OPA_RS1;
        op_b_sel   = OPB_IMM;
        imm_fmt    = IMM_NONE;
        result_sel = RES_ALU;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        is_branch  = 1'b0;
        is_jump    = 1'b0;

        case (opcode)
            OPC_OP: begin
                alu_op    = f3_to_op(funct3, funct7_b5, 1'b1);
                op_b_sel  = OPB_RS2;
                reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = f3_to_op(funct3, funct7_b5, 1'b0);
                imm_fmt   = IMM_I;
                reg_write = 1'b1;
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                op_a_sel  = OPA_ZERO;
                imm_fmt   = IMM_U;
                reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                op_a_sel  = OPA_PC;
                imm_fmt   = IMM_U;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                imm_fmt    = IMM_I;
                result_sel = RES_MEM;
                reg_write  = 1'b1;
            end
            OPC_STORE: begin
                imm_fmt   = IMM_S;
                mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                alu_op    = ALU_SUB;
                op_b_sel  = OPB_RS2;
                imm_fmt   = IMM_B;
                is_branch = 1'b1;
            end
            OPC_JAL: begin
                op_a_sel   = OPA_PC;
                imm_fmt    = IMM_J;
                result_sel = RES_PC4;    // Link address
                reg_write  = 1'b1;
                is_jump    = 1'b1;
            end
            OPC_JALR: begin
                imm_fmt    = IMM_I;
                result_sel = RES_PC4;
                reg_write  = 1'b1;
                is_jump    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- execute/operand_select.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module operand_select (
    input  logic [`XLEN-1:0]        instr,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic [`XLEN-1:0]        fwd_mem_data,
    input  logic [`XLEN-1:0]        fwd_wb_data,
    input  exe_ctrl_pkg::fwd_sel_e  fwd_a,
    input  exe_ctrl_pkg::fwd_sel_e  fwd_b,
    input  rv_isa_pkg::imm_fmt_e    imm_fmt,
    input  exe_ctrl_pkg::op_a_sel_e op_a_sel,
    input  exe_ctrl_pkg::op_b_sel_e op_b_sel,
    output logic [`XLEN-1:0]        op_a,
    output logic [`XLEN-1:0]        op_b,
    output logic [`XLEN-1:0]        rs1_val,
    output logic [`XLEN-1:0]        rs2_val,
    output logic [`XLEN-1:0]        imm
);
    import rv_isa_pkg::*;
    import exe_ctrl_pkg::*;

    // MEM checked first so the younger result wins
    function automatic logic [`XLEN-1:0] fwd_pick(input fwd_sel_e sel,
                                                  input logic [`XLEN-1:0] rf_val,
                                                  input logic [`XLEN-1:0] mem_val,
                                                  input logic [`XLEN-1:0] wb_val);
        if ((sel & FWD_MEM) != 2'b00)
            fwd_pick = mem_val;
        else if ((sel & FWD_WB) != 2'b00)
            fwd_pick = wb_val;
        else
            fwd_pick = rf_val;
    endfunction

    assign rs1_val = fwd_pick(fwd_a, rs1_data, fwd_mem_data, fwd_wb_data);
    assign rs2_val = fwd_pick(fwd_b, rs2_data, fwd_mem_data, fwd_wb_data);

    always_comb begin
        case (imm_fmt)
            IMM_I:   imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            IMM_S:   imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        case (op_a_sel)
            OPA_RS1: op_a = rs1_val;
            OPA_PC:  op_a = pc;       // AUIPC / JAL
            default: op_a = '0;
        endcase
    end

    assign op_b = (op_b_sel == OPB_IMM) ? imm : rs2_val;

endmodule

//--- execute/alu.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module alu (
    input  logic [`XLEN-1:0]      op_a,
    input  logic [`XLEN-1:0]      op_b,
    input  exe_ctrl_pkg::alu_op_e alu_op,
    output logic [`XLEN-1:0]      result,
    output logic                  zero,
    output logic                  negative
);
    import exe_ctrl_pkg::*;

    logic [4:0]        shamt;
    logic              lt_signed;
    logic              lt_unsigned;

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;        // LUI
            default:    result = '0;
        endcase
    end

    // Flags off the final result
    assign zero     = (result == '0);
    assign negative = result[`XLEN-1];

endmodule

//--- execute/branch_unit.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module branch_unit (
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    input  logic [`XLEN-1:0] imm,
    input  logic             is_branch,
    input  logic             is_jump,
    output logic             pc_next_set,
    output logic [`XLEN-1:0] pc_target
);
    import rv_isa_pkg::*;

    branch_f3_e        cond_f3;
    logic              equal;
    logic              lt_s;
    logic              lt_u;
    logic              taken;
    logic              is_jalr;
    logic [`XLEN-1:0]  base;
    logic [`XLEN-1:0]  sum;

    assign cond_f3 = branch_f3_e'(instr[14:12]);

    // Compare forwarded values, not register indices
    assign equal = (rs1_val == rs2_val);
    assign lt_s  = $signed(rs1_val) < $signed(rs2_val);
    assign lt_u  = rs1_val < rs2_val;

    always_comb begin
        case (cond_f3)
            F3_BEQ:  taken = equal;
            F3_BNE:  taken = !equal;
            F3_BLT:  taken = lt_s;
            F3_BGE:  taken = !lt_s;
            F3_BLTU: taken = lt_u;
            F3_BGEU: taken = !lt_u;
            default: taken = 1'b0;    // Reserved funct3
        endcase
    end

    assign pc_next_set = (is_branch && taken) || is_jump;

    assign is_jalr   = is_jump && (instr[6:0] == OPC_JALR);
    assign base      = is_jalr ? rs1_val : pc;
    assign sum       = base + imm;
    assign pc_target = is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum;  // JALR drops bit 0

endmodule

//--- execute/exe_mem_reg.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`XLEN-1:0]          instr,
    input  logic [`XLEN-1:0]          pc,
    input  logic [`XLEN-1:0]          alu_result,
    input  logic [`XLEN-1:0]          store_data,
    input  logic                      reg_write,
    input  logic                      mem_write,
    input  exe_ctrl_pkg::result_sel_e result_sel,
    output logic [`XLEN-1:0]          alu_result_mem,
    output logic [`XLEN-1:0]          write_data_mem,
    output logic [`XLEN-1:0]          pc_plus4_mem,
    output logic [`REG_ADDR_W-1:0]    rd_mem,
    output logic [2:0]                funct3_mem,
    output logic                      reg_write_mem,
    output logic                      mem_write_mem,
    output exe_ctrl_pkg::result_sel_e result_sel_mem
);
    import exe_ctrl_pkg::*;

    logic [`XLEN-1:0]       pc_plus4;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;

    assign pc_plus4 = pc + `XLEN'(4);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];     // Load/store width for the MEM stage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_result_mem <= '0;
            write_data_mem <= '0;
            pc_plus4_mem   <= '0;
            rd_mem         <= '0;
            funct3_mem     <= '0;
            reg_write_mem  <= 1'b0;
            mem_write_mem  <= 1'b0;
            result_sel_mem <= RES_ALU;
        end else begin
            // No stall path, new bundle every cycle
            alu_result_mem <= alu_result;
            write_data_mem <= store_data;
            pc_plus4_mem   <= pc_plus4;
            rd_mem         <= rd;
            funct3_mem     <= funct3;
            reg_write_mem  <= reg_write;
            mem_write_mem  <= mem_write;
            result_sel_mem <= result_sel;
        end
    end

endmodule

//--- execute/execute.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module execute (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`XLEN-1:0]              pc,
    input  logic [`XLEN-1:0]              instr,
    input  logic [`XLEN-1:0]              rs1_data,
    input  logic [`XLEN-1:0]              rs2_data,
    input  logic [`XLEN-1:0]              fwd_mem_data,
    input  logic [`XLEN-1:0]              fwd_wb_data,
    input  exe_ctrl_pkg::fwd_sel_e        fwd_a,
    input  exe_ctrl_pkg::fwd_sel_e        fwd_b,
    output logic                          pc_next_set,
    output logic [`XLEN-1:0]              pc_target,
    output logic [`XLEN-1:0]              alu_result_mem,
    output logic [`XLEN-1:0]              write_data_mem,
    output logic [`XLEN-1:0]              pc_plus4_mem,
    output logic [`REG_ADDR_W-1:0]        rd_mem,
    output logic [2:0]                    funct3_mem,
    output logic                          reg_write_mem,
    output logic                          mem_write_mem,
    output exe_ctrl_pkg::result_sel_e     result_sel_mem
);
    import rv_isa_pkg::*;
    import exe_ctrl_pkg::*;

    alu_op_e             alu_op;
    op_a_sel_e           op_a_sel;
    op_b_sel_e           op_b_sel;
    imm_fmt_e            imm_fmt;
    result_sel_e         result_sel;
    logic                reg_write;
    logic                mem_write;
    logic                is_branch;
    logic                is_jump;

    logic [`XLEN-1:0]    op_a;
    logic [`XLEN-1:0]    op_b;
    logic [`XLEN-1:0]    rs1_val;     // After forwarding
    logic [`XLEN-1:0]    rs2_val;     // After forwarding, also store data
    logic [`XLEN-1:0]    imm;
    logic [`XLEN-1:0]    alu_result;

    alu_control u_alu_control (
        .instr      (instr),
        .alu_op     (alu_op),
        .op_a_sel   (op_a_sel),
        .op_b_sel   (op_b_sel),
        .imm_fmt    (imm_fmt),
        .result_sel (result_sel),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .is_branch  (is_branch),
        .is_jump    (is_jump)
    );

    operand_select u_operand_select (
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd_mem_data (fwd_mem_data),
        .fwd_wb_data  (fwd_wb_data),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .imm_fmt      (imm_fmt),
        .op_a_sel     (op_a_sel),
        .op_b_sel     (op_b_sel),
        .op_a         (op_a),
        .op_b         (op_b),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .imm          (imm)
    );

    alu u_alu (
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_op   (alu_op),
        .result   (alu_result),
        .zero     (),          // Branch unit compares the operands itself
        .negative ()
    );

    branch_unit u_branch_unit (
        .instr       (instr),
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .imm         (imm),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .pc_next_set (pc_next_set),
        .pc_target   (pc_target)
    );

    exe_mem_reg u_exe_mem_reg (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr          (instr),
        .pc             (pc),
        .alu_result     (alu_result),
        .store_data     (rs2_val),
        .reg_write      (reg_write),
        .mem_write      (mem_write),
        .result_sel     (result_sel),
        .alu_result_mem (alu_result_mem),
        .write_data_mem (write_data_mem),
        .pc_plus4_mem   (pc_plus4_mem),
        .rd_mem         (rd_mem),
        .funct3_mem     (funct3_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_write_mem  (mem_write_mem),
        .result_sel_mem (result_sel_mem)
    );

endmodule

//--- dv/execute_chk.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module execute_chk (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      reg_write_mem,
    input logic                      mem_write_mem,
    input exe_ctrl_pkg::result_sel_e result_sel_mem,
    input logic                      is_branch,
    input logic                      is_jump,
    input logic                      pc_next_set,
    input logic [`XLEN-1:0]          pc_target
);
    import exe_ctrl_pkg::*;

    // Memory-stage controls held clear through reset
    ctrl_clear_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!reg_write_mem && !mem_write_mem && result_sel_mem == RES_ALU))
        else $error("memory-stage control bits not clear during reset");

    redirect_aligned: assert property (@(posedge clk)
        pc_next_set |-> !pc_target[0])
        else $error("redirect target has bit 0 set");

    // Only branches and jumps may redirect
    redirect_needs_cti: assert property (@(posedge clk)
        (!is_branch && !is_jump) |-> !pc_next_set)
        else $error("redirect raised without a branch or jump");

endmodule

//--- dv/execute_tb.sv
`timescale 1ns/10ps
`include "execute_settings.svh"

module execute_tb;
    import rv_isa_pkg::*;
    import exe_ctrl_pkg::*;

    localparam int NUM_INSTR  = 2000;
    localparam int TIMEOUT_NS = 20000;
    localparam logic [31:0] NOP = 32'h0000_0013;   // ADDI x0,x0,0

    logic                   clk;
    logic                   arst_n;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       fwd_mem_data;
    logic [`XLEN-1:0]       fwd_wb_data;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
    logic                   pc_next_set;
    logic [`XLEN-1:0]       pc_target;
    logic [`XLEN-1:0]       alu_result_mem;
    logic [`XLEN-1:0]       write_data_mem;
    logic [`XLEN-1:0]       pc_plus4_mem;
    logic [`REG_ADDR_W-1:0] rd_mem;
    logic [2:0]             funct3_mem;
    logic                   reg_write_mem;
    logic                   mem_write_mem;
    result_sel_e            result_sel_mem;

    integer                 seed;
    logic                   m_next_set;
    logic [`XLEN-1:0]       m_target;
    logic                   m_chk_target;
    logic                   exp_valid;     // A bundle is in flight
    logic                   exp_chk_alu;
    logic [`XLEN-1:0]       exp_alu;
    logic [`XLEN-1:0]       exp_wdata;
    logic [`XLEN-1:0]       exp_pc4;
    logic [4:0]             exp_rd;
    logic [2:0]             exp_f3;
    logic                   exp_rw;
    logic                   exp_mw;
    result_sel_e            exp_rsel;

    execute UUT (.*);

    bind execute execute_chk u_execute_chk (
        .clk            (clk),
        .arst_n         (arst_n),
        .reg_write_mem  (reg_write_mem),
        .mem_write_mem  (mem_write_mem),
        .result_sel_mem (result_sel_mem),
        .is_branch      (is_branch),
        .is_jump        (is_jump),
        .pc_next_set    (pc_next_set),
        .pc_target      (pc_target)
    );

    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, got, want);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // RV32I arithmetic as the ISA defines it
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  alu_ref = alt ? a - b : a + b;
            3'b001:  alu_ref = a << b[4:0];
            3'b010:  alu_ref = {31'b0, $signed(a) < $signed(b)};
            3'b011:  alu_ref = {31'b0, a < b};
            3'b100:  alu_ref = a ^ b;
            3'b101:  alu_ref = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  branch_taken = (a == b);
            3'b001:  branch_taken = (a != b);
            3'b100:  branch_taken = $signed(a) < $signed(b);
            3'b101:  branch_taken = $signed(a) >= $signed(b);
            3'b110:  branch_taken = a < b;
            3'b111:  branch_taken = a >= b;
            default: branch_taken = 1'b0;
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] d;
        logic [6:0]  opc;
        int          kind;
        r    = $random(seed);
        word = $random(seed);
        kind = int'(r[7:4]) % 10;
        case (kind)
            0:       opc = OPC_OP;
            1:       opc = OPC_OP_IMM;
            2:       opc = OPC_LUI;
            3:       opc = OPC_AUIPC;
            4:       opc = OPC_LOAD;
            5:       opc = OPC_STORE;
            6:       opc = OPC_BRANCH;
            7:       opc = OPC_JAL;
            default: opc = OPC_JALR;
        endcase
        word[6:0] = opc;
        if (opc == OPC_OP || (opc == OPC_OP_IMM && word[13:12] == 2'b01)) begin
            word[31]    = 1'b0;           // Legal funct7 leaves only bit 30 free
            word[29:25] = 5'b0;
            if (word[14:12] != 3'b000 && word[14:12] != 3'b101)
                word[30] = 1'b0;
        end
        if (opc == OPC_BRANCH)
            word[13] = word[14] & word[13];   // Skip reserved 010 / 011
        if (opc == OPC_JALR)
            word[14:12] = 3'b000;
        if (kind == 9)
            word = NOP;
        instr <= word;
        d = $random(seed);
        pc <= {d[31:2], 2'b00};
        d = $random(seed);
        if (r[3:2] == 2'b00) begin
            // Equal operands so BEQ / BGE paths get hit
            rs1_data     <= d;
            rs2_data     <= d;
            fwd_mem_data <= d;
            fwd_wb_data  <= d;
        end else begin
            rs1_data     <= d;
            rs2_data     <= $random(seed);
            fwd_mem_data <= $random(seed);
            fwd_wb_data  <= $random(seed);
        end
        fwd_a <= fwd_sel_e'(r[1:0]);    // 2'b11 exercises MEM priority
        fwd_b <= fwd_sel_e'(r[9:8]);
    endtask

    task automatic predict();
        logic [1:0]  sa;
        logic [1:0]  sb;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        sa    = fwd_a;
        sb    = fwd_b;
        a     = sa[1] ? fwd_mem_data : (sa[0] ? fwd_wb_data : rs1_data);
        b     = sb[1] ? fwd_mem_data : (sb[0] ? fwd_wb_data : rs2_data);
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        m_next_set   = 1'b0;
        m_target     = '0;
        m_chk_target = 1'b0;
        exp_chk_alu  = 1'b1;
        exp_alu      = '0;
        exp_rw       = 1'b0;
        exp_mw       = 1'b0;
        exp_rsel     = RES_ALU;
        case (instr[6:0])
            OPC_OP: begin
                exp_alu = alu_ref(f3, instr[30], a, b);
                exp_rw  = 1'b1;
            end
            OPC_OP_IMM: begin
                exp_alu = alu_ref(f3, (f3 == 3'b101) && instr[30], a, imm_i);
                exp_rw  = 1'b1;
            end
            OPC_LUI: begin
                exp_alu = imm_u;
                exp_rw  = 1'b1;
            end
            OPC_AUIPC: begin
                exp_alu = pc + imm_u;
                exp_rw  = 1'b1;
            end
            OPC_LOAD: begin
                exp_alu  = a + imm_i;
                exp_rw   = 1'b1;
                exp_rsel = RES_MEM;
            end
            OPC_STORE: begin
                exp_alu = a + imm_s;
                exp_mw  = 1'b1;
            end
            OPC_BRANCH: begin
                exp_alu      = a - b;
                m_next_set   = branch_taken(f3, a, b);
                m_target     = pc + imm_b;
                m_chk_target = 1'b1;
            end
            OPC_JAL: begin
                exp_chk_alu  = 1'b0;
                exp_rw       = 1'b1;
                exp_rsel     = RES_PC4;
                m_next_set   = 1'b1;
                m_target     = pc + imm_j;
                m_chk_target = 1'b1;
            end
            OPC_JALR: begin
                exp_alu      = a + imm_i;
                exp_rw       = 1'b1;
                exp_rsel     = RES_PC4;
                m_next_set   = 1'b1;
                m_target     = (a + imm_i) & 32'hFFFF_FFFE;
                m_chk_target = 1'b1;
            end
            default: exp_chk_alu = 1'b0;
        endcase
        exp_wdata = b;
        exp_pc4   = pc + 32'd4;
        exp_rd    = instr[11:7];
        exp_f3    = f3;
        exp_valid = 1'b1;
    endtask

    task automatic check_comb();
        compare_value("pc_next_set", 32'(pc_next_set), 32'(m_next_set));
        if (m_chk_target)
            compare_value("pc_target", pc_target, m_target);
    endtask

    task automatic check_registered();
        if (exp_chk_alu)
            compare_value("alu_result_mem", alu_result_mem, exp_alu);
        compare_value("write_data_mem", write_data_mem, exp_wdata);
        compare_value("pc_plus4_mem", pc_plus4_mem, exp_pc4);
        compare_value("rd_mem", 32'(rd_mem), 32'(exp_rd));
        compare_value("funct3_mem", 32'(funct3_mem), 32'(exp_f3));
        compare_value("reg_write_mem", 32'(reg_write_mem), 32'(exp_rw));
        compare_value("mem_write_mem", 32'(mem_write_mem), 32'(exp_mw));
        compare_value("result_sel_mem", 32'(result_sel_mem), 32'(exp_rsel));
    endtask

    // Stops the run if the main sequence never completes
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the stimulus sequence did not finish in %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        seed         = 84;
        exp_valid    = 1'b0;
        clk          = 1'b0;
        arst_n       = 1'b1;
        pc           = '0;
        instr        = NOP;
        rs1_data     = '0;
        rs2_data     = '0;
        fwd_mem_data = '0;
        fwd_wb_data  = '0;
        fwd_a        = FWD_NONE;
        fwd_b        = FWD_NONE;

        @(posedge clk);
        arst_n <= 1'b0;             // Clean falling edge on the async reset
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_value("reg_write_mem", 32'(reg_write_mem), 32'd0);
        compare_value("mem_write_mem", 32'(mem_write_mem), 32'd0);
        compare_value("result_sel_mem", 32'(result_sel_mem), 32'(RES_ALU));
        compare_value("alu_result_mem", alu_result_mem, 32'd0);
        @(posedge clk);
        arst_n <= 1'b1;

        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            if (exp_valid)
                check_registered();   // Bundle from the previous instruction
            predict();
            check_comb();
        end
        @(posedge clk);
        instr <= NOP;
        @(negedge clk);
        check_registered();

        if (exp_valid) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "no instruction was checked");
        end
    end

endmodule

//--- execute.f
+incdir+common
common/rv_isa_pkg.sv
common/exe_ctrl_pkg.sv
execute/alu_control.sv
execute/operand_select.sv
execute/alu.sv
execute/branch_unit.sv
execute/exe_mem_reg.sv
execute/execute.sv
dv/execute_chk.sv
dv/execute_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= execute.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator, run it and search $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
